// File: project.f
hdl/mem_pkg.sv
hdl/dmem_if.sv
hdl/load_align.sv
hdl/store_gen.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/mem_top.sv
tests/tb_clkgen.sv
tests/tb_mem_top.sv

// File: Makefile
SIM      := verilator
TOP      := tb_mem_top
FILELIST := project.f
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_top;
    import mem_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int RANDOM_OPS     = 400;

    typedef struct packed {
        logic                      valid;
        logic [DATA_WIDTH-1:0]     pc;
        logic [DATA_WIDTH-1:0]     inst;
        logic [DATA_WIDTH-1:0]     result;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [DATA_WIDTH-1:0]     load_data;
    } exp_t;

    logic                      clk;
    logic                      rst_n;
    logic                      valid_i;
    logic [DATA_WIDTH-1:0]     pc_i;
    logic [DATA_WIDTH-1:0]     inst_i;
    logic [DATA_WIDTH-1:0]     result_i;
    logic [DATA_WIDTH-1:0]     dmem_addr_i;
    logic [DATA_WIDTH-1:0]     rs2_data_i;
    logic [REG_ADDR_WIDTH-1:0] rd_addr_i;
    logic                      valid_o;
    logic [DATA_WIDTH-1:0]     pc_o;
    logic [DATA_WIDTH-1:0]     inst_o;
    logic [DATA_WIDTH-1:0]     result_o;
    logic [DATA_WIDTH-1:0]     load_data_o;
    logic [REG_ADDR_WIDTH-1:0] rd_addr_o;

    logic [DATA_WIDTH-1:0] shadow [DMEM_WORDS];  // Expected RAM contents
    exp_t                  exp_q [$];
    logic [31:0]           lcg_state = 32'h44a;
    int                    driven_cnt = 0;
    int                    checked_cnt = 0;

    tb_clkgen i_clkgen (.clk_o(clk), .rst_n_o(rst_n));

    mem_top i_dut (
        .clk(clk), .rst_n_i(rst_n),
        .valid_i(valid_i), .pc_i(pc_i), .inst_i(inst_i), .result_i(result_i),
        .dmem_addr_i(dmem_addr_i), .rs2_data_i(rs2_data_i), .rd_addr_i(rd_addr_i),
        .valid_o(valid_o), .pc_o(pc_o), .inst_o(inst_o), .result_o(result_o),
        .load_data_o(load_data_o), .rd_addr_o(rd_addr_o)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected load_data_o for a word read with the given funct3
    function automatic logic [31:0] ref_load(input logic [2:0] f3, input logic [1:0] lo,
                                             input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> {lo, 3'b000});
        h = lo[1] ? word[31:16] : word[15:0];  // Bit 0 plays no part
        case (f3)
            SIZE_BYTE:   return {{24{b[7]}}, b};
            SIZE_HALF:   return {{16{h[15]}}, h};
            SIZE_BYTE_U: return {24'h0, b};
            SIZE_HALF_U: return {16'h0, h};
            default:     return word;
        endcase
    endfunction

    function automatic void write_shadow(input logic [2:0] f3, input logic [31:0] addr,
                                         input logic [31:0] data);
        logic [DMEM_AW-1:0] idx;
        logic [31:0]        w;
        idx = addr[DMEM_AW+1:2];  // Wraps like the RAM
        w   = shadow[idx];
        case (f3)
            SIZE_BYTE: w[{addr[1:0], 3'b000} +: 8] = data[7:0];
            SIZE_HALF: begin
                if (addr[1]) w[31:16] = data[15:0];
                else         w[15:0]  = data[15:0];
            end
            default:   w = data;
        endcase
        shadow[idx] = w;
    endfunction

    function automatic logic [31:0] make_inst(input logic [6:0] op, input logic [2:0] f3);
        logic [31:0] r;
        r = next_rand();
        return {r[31:15], f3, r[11:7], op};  // Random register and immediate fields
    endfunction

    function automatic logic [2:0] pick_load_f3(input logic [31:0] r);
        case (r % 32'd5)
            32'd0:   return SIZE_BYTE;
            32'd1:   return SIZE_HALF;
            32'd2:   return SIZE_WORD;
            32'd3:   return SIZE_BYTE_U;
            default: return SIZE_HALF_U;
        endcase
    endfunction

    function automatic logic [2:0] pick_store_f3(input logic [31:0] r);
        case (r % 32'd3)
            32'd0:   return SIZE_BYTE;
            32'd1:   return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s actual=%08h expected=%08h",
                     $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "Output mismatch on %s", name);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Regression failed");
        $fatal(1, "Simulation stopped by a timeout");
    endtask

    // One instruction per cycle with its expected outputs queued as it is driven
    task automatic drive_instr(input logic valid, input logic [31:0] inst,
                               input logic [31:0] addr, input logic [31:0] data);
        exp_t        e;
        logic [31:0] r;
        logic [6:0]  op;
        @(posedge clk);
        #1;
        r           = next_rand();
        valid_i     = valid;
        pc_i        = next_rand();
        inst_i      = inst;
        result_i    = next_rand();
        dmem_addr_i = addr;
        rs2_data_i  = data;
        rd_addr_i   = r[4:0];
        op          = inst[6:0];
        e.valid     = valid;
        e.pc        = pc_i;
        e.inst      = inst;
        e.result    = result_i;
        e.rd        = r[4:0];
        if (op == OPCODE_LOAD || op == OPCODE_STORE) begin
            // Read happens before this store's own write
            e.load_data = ref_load(inst[14:12], addr[1:0], shadow[addr[DMEM_AW+1:2]]);
        end else begin
            e.load_data = '0;
        end
        if (valid && op == OPCODE_STORE) write_shadow(inst[14:12], addr, data);
        exp_q.push_back(e);
        driven_cnt++;
    endtask

    task automatic issue_load(input logic [2:0] f3, input logic [31:0] addr,
                              input logic valid);
        drive_instr(valid, make_inst(OPCODE_LOAD, f3), addr, next_rand());
    endtask

    task automatic issue_store(input logic [2:0] f3, input logic [31:0] addr,
                               input logic [31:0] data, input logic valid);
        drive_instr(valid, make_inst(OPCODE_STORE, f3), addr, data);
    endtask

    task automatic issue_other(input logic valid);
        logic [6:0] op;
        op = 7'(next_rand());
        if (op == OPCODE_LOAD || op == OPCODE_STORE) op = op ^ 7'b0010000;
        drive_instr(valid, make_inst(op, 3'(next_rand())), next_rand(), next_rand());
    endtask

    task automatic read_all_sizes(input logic [31:0] addr);
        issue_load(SIZE_BYTE, addr, 1'b1);
        issue_load(SIZE_BYTE_U, addr, 1'b1);
        issue_load(SIZE_HALF, addr, 1'b1);
        issue_load(SIZE_HALF_U, addr, 1'b1);
        issue_load(SIZE_WORD, addr, 1'b1);
    endtask

    // Outputs checked mid-cycle after the edge that captured the inputs
    initial begin : compare_outputs
        exp_t e;
        forever begin
            @(posedge clk);
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                @(negedge clk);
                check_value("valid_o", 32'(valid_o), 32'(e.valid));
                check_value("pc_o", pc_o, e.pc);
                check_value("inst_o", inst_o, e.inst);
                check_value("result_o", result_o, e.result);
                check_value("rd_addr_o", 32'(rd_addr_o), 32'(e.rd));
                check_value("load_data_o", load_data_o, e.load_data);
                checked_cnt++;
            end
        end
    end

    initial begin : stimulus
        int          wait_cnt;
        logic [31:0] r;
        logic [31:0] a;
        valid_i     = 1'b0;
        pc_i        = '0;
        inst_i      = '0;
        result_i    = '0;
        dmem_addr_i = '0;
        rs2_data_i  = '0;
        rd_addr_i   = '0;
        for (int w = 0; w < DMEM_WORDS; w++) shadow[w] = '0;

        wait_cnt = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT_CYCLES) abort_on_timeout("reset release");
        end
        check_value("valid_o", 32'(valid_o), 32'h0);
        check_value("pc_o", pc_o, 32'h0);
        check_value("inst_o", inst_o, 32'h0);
        check_value("result_o", result_o, 32'h0);
        check_value("rd_addr_o", 32'(rd_addr_o), 32'h0);
        check_value("load_data_o", load_data_o, 32'h0);

        repeat (20) begin
            r = next_rand();
            issue_other(r[9]);
        end

        // Word write and read back through a plain and a wrapped address
        issue_store(SIZE_WORD, 32'h0000_0080, 32'hdead_beef, 1'b1);
        issue_load(SIZE_WORD, 32'h0000_0080, 1'b1);
        issue_store(SIZE_WORD, 32'h1000_03fc, next_rand(), 1'b1);
        issue_load(SIZE_WORD, 32'h0000_03fc, 1'b1);

        // Every lane with both values of the sign bit
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            issue_store(SIZE_WORD, 32'h40, next_rand(), 1'b1);
            issue_store(SIZE_BYTE, 32'h40 + 32'(i % 4), {r[31:8], i[2], r[6:0]}, 1'b1);
            read_all_sizes(32'h40 + 32'(i % 4));
            r = next_rand();
            issue_store(SIZE_WORD, 32'h44, next_rand(), 1'b1);
            issue_store(SIZE_HALF, 32'h44 + 32'(i % 4), {r[31:16], i[2], r[14:0]}, 1'b1);
            read_all_sizes(32'h44 + 32'(i % 4));
        end

        // Stores with valid low must not reach memory
        issue_store(SIZE_WORD, 32'h60, 32'h1357_9bdf, 1'b1);
        issue_store(SIZE_WORD, 32'h60, 32'hffff_0000, 1'b0);
        issue_store(SIZE_BYTE, 32'h61, 32'h0000_00aa, 1'b0);
        issue_store(SIZE_HALF, 32'h62, 32'h0000_5555, 1'b0);
        read_all_sizes(32'h60);

        repeat (RANDOM_OPS) begin
            r = next_rand();
            a = next_rand();
            a = {a[31:10], 4'b0000, a[5:0]};  // 16 words with random high bits that wrap
            case (r % 32'd8)
                32'd0, 32'd1, 32'd2:
                    issue_load(pick_load_f3(next_rand()), a, r[7:4] != 4'h0);
                32'd3, 32'd4:
                    issue_store(pick_store_f3(next_rand()), a, next_rand(), r[7:4] != 4'h0);
                default:
                    issue_other(r[7:4] != 4'h0);
            endcase
        end
        issue_other(1'b0);

        wait_cnt = 0;
        while (checked_cnt != driven_cnt) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT_CYCLES) abort_on_timeout("the last output check");
        end
        $display("Regression passed");
        $finish;
    end

endmodule : tb_mem_top

`default_nettype wire

// File: tests/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD_NS = 5;  // 10 ns clock
    localparam int RESET_CYCLES   = 4;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Release just after an edge and away from the sampling point
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule : tb_clkgen

`default_nettype wire

// File: hdl/mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_top (
    input  logic                              clk,
    input  logic                              rst_n_i,
    // Execute side
    input  logic                              valid_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     pc_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     inst_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     result_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     dmem_addr_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     rs2_data_i,
    input  logic [mem_pkg::REG_ADDR_WIDTH-1:0] rd_addr_i,
    // Write-back side
    output logic                              valid_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]     pc_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]     inst_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]     result_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]     load_data_o,
    output logic [mem_pkg::REG_ADDR_WIDTH-1:0] rd_addr_o
);

    dmem_if dmem_bus ();  // Stage to RAM

    mem_stage i_mem_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .result_i    (result_i),
        .dmem_addr_i (dmem_addr_i),
        .rs2_data_i  (rs2_data_i),
        .rd_addr_i   (rd_addr_i),
        .valid_o     (valid_o),
        .pc_o        (pc_o),
        .inst_o      (inst_o),
        .result_o    (result_o),
        .load_data_o (load_data_o),
        .rd_addr_o   (rd_addr_o),
        .dmem        (dmem_bus.master)
    );

    // Store written at the edge that ends its cycle in the stage
    data_ram i_data_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .dmem    (dmem_bus.slave)
    );

endmodule : mem_top

`default_nettype wire

// File: hdl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  logic   clk,
    input  logic   rst_n_i,
    dmem_if.slave  dmem
);
    import mem_pkg::*;

    logic [DATA_WIDTH-1:0] mem [DMEM_WORDS];
    logic [DMEM_AW-1:0]    word_idx;

    // Upper address bits dropped so accesses wrap
    assign word_idx = dmem.addr[DMEM_AW+1:2];

    // Read side is asynchronous
    assign dmem.rdata = dmem.en ? mem[word_idx] : '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < DMEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (dmem.wen) begin
            for (int b = 0; b < MASK_WIDTH; b++) begin
                if (dmem.wmask[b]) begin
                    mem[word_idx][8*b +: 8] <= dmem.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule : data_ram

`default_nettype wire

// File: hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                              clk,
    input  logic                              rst_n_i,
    // From execute
    input  logic                              valid_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     pc_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     inst_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     result_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     dmem_addr_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     rs2_data_i,
    input  logic [mem_pkg::REG_ADDR_WIDTH-1:0] rd_addr_i,
    // To write-back
    output logic                              valid_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]     pc_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]     inst_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]     result_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]     load_data_o,
    output logic [mem_pkg::REG_ADDR_WIDTH-1:0] rd_addr_o,
    // Data RAM port
    dmem_if.master                            dmem
);
    import mem_pkg::*;

    logic                      valid_q;
    logic [DATA_WIDTH-1:0]     pc_q;
    logic [DATA_WIDTH-1:0]     inst_q;
    logic [DATA_WIDTH-1:0]     result_q;
    logic [DATA_WIDTH-1:0]     addr_q;
    logic [DATA_WIDTH-1:0]     rs2_q;
    logic [REG_ADDR_WIDTH-1:0] rd_q;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [2:0] mem_size;
    logic       is_load;
    logic       is_store;

    // Stage registers load on every cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            pc_q     <= '0;
            inst_q   <= '0;  // Zero opcode keeps en and wen low
            result_q <= '0;
            addr_q   <= '0;
            rs2_q    <= '0;
            rd_q     <= '0;
        end else begin
            valid_q  <= valid_i;
            pc_q     <= pc_i;
            inst_q   <= inst_i;
            result_q <= result_i;
            addr_q   <= dmem_addr_i;
            rs2_q    <= rs2_data_i;
            rd_q     <= rd_addr_i;
        end
    end

    // Opcode and funct3 share positions in I and S formats
    assign opcode = inst_q[6:0];
    assign funct3 = inst_q[14:12];

    assign is_load  = (opcode == OPCODE_LOAD);
    assign is_store = (opcode == OPCODE_STORE);

    // Access size from the opcode and funct3 pair
    always_comb begin
        case ({opcode, funct3})
            {OPCODE_LOAD,  SIZE_BYTE}:   mem_size = SIZE_BYTE;    // LB
            {OPCODE_LOAD,  SIZE_HALF}:   mem_size = SIZE_HALF;    // LH
            {OPCODE_LOAD,  SIZE_WORD}:   mem_size = SIZE_WORD;    // LW
            {OPCODE_LOAD,  SIZE_BYTE_U}: mem_size = SIZE_BYTE_U;  // LBU
            {OPCODE_LOAD,  SIZE_HALF_U}: mem_size = SIZE_HALF_U;  // LHU
            {OPCODE_STORE, SIZE_BYTE}:   mem_size = SIZE_BYTE;    // SB
            {OPCODE_STORE, SIZE_HALF}:   mem_size = SIZE_HALF;    // SH
            {OPCODE_STORE, SIZE_WORD}:   mem_size = SIZE_WORD;    // SW
            default:                     mem_size = SIZE_BYTE;
        endcase
    end

    assign dmem.en   = is_load | is_store;
    assign dmem.wen  = valid_q & is_store;  // Only a live store may write
    assign dmem.addr = addr_q;

    store_gen i_store_gen (
        .size_i    (mem_size),
        .addr_lo_i (addr_q[1:0]),
        .data_i    (rs2_q),
        .wdata_o   (dmem.wdata),
        .wmask_o   (dmem.wmask)
    );

    load_align i_load_align (
        .size_i    (mem_size),
        .addr_lo_i (addr_q[1:0]),
        .data_i    (dmem.rdata),
        .data_o    (load_data_o)
    );

    assign valid_o   = valid_q;
    assign pc_o      = pc_q;
    assign inst_o    = inst_q;
    assign result_o  = result_q;
    assign rd_addr_o = rd_q;

endmodule : mem_stage

`default_nettype wire

// File: hdl/store_gen.sv
`timescale 1ns/1ps
`default_nettype none

module store_gen (
    input  logic [2:0]                     size_i,
    input  logic [1:0]                     addr_lo_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0] data_i,
    output logic [mem_pkg::DATA_WIDTH-1:0] wdata_o,
    output logic [mem_pkg::MASK_WIDTH-1:0] wmask_o
);
    import mem_pkg::*;

    // Data is copied into every lane and the mask picks the lanes written
    always_comb begin
        case (size_i)
            SIZE_BYTE, SIZE_BYTE_U: begin
                wmask_o = MASK_WIDTH'(1) << addr_lo_i;
                wdata_o = {MASK_WIDTH{data_i[7:0]}};
            end
            SIZE_HALF, SIZE_HALF_U: begin
                wmask_o = {{2{addr_lo_i[1]}}, {2{~addr_lo_i[1]}}};  // Upper or lower half
                wdata_o = {2{data_i[15:0]}};
            end
            SIZE_WORD: begin
                wmask_o = '1;
                wdata_o = data_i;
            end
            default: begin
                wmask_o = '1;
                wdata_o = data_i;
            end
        endcase
    end

endmodule : store_gen

`default_nettype wire

// File: hdl/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  logic [2:0]                     size_i,
    input  logic [1:0]                     addr_lo_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0] data_i,
    output logic [mem_pkg::DATA_WIDTH-1:0] data_o
);
    import mem_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Lane pick from the low address bits
    assign byte_sel = data_i[8*addr_lo_i +: 8];
    assign half_sel = addr_lo_i[1] ? data_i[31:16] : data_i[15:0];

    always_comb begin
        case (size_i)
            SIZE_BYTE:   data_o = {{(DATA_WIDTH-8){byte_sel[7]}}, byte_sel};
            SIZE_HALF:   data_o = {{(DATA_WIDTH-16){half_sel[15]}}, half_sel};
            SIZE_BYTE_U: data_o = {{(DATA_WIDTH-8){1'b0}}, byte_sel};
            SIZE_HALF_U: data_o = {{(DATA_WIDTH-16){1'b0}}, half_sel};
            SIZE_WORD:   data_o = data_i;  // Low bits ignored
            default:     data_o = data_i;
        endcase
    end

endmodule : load_align

`default_nettype wire

// File: hdl/dmem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dmem_if;
    import mem_pkg::*;

    logic                  en;     // Access in progress
    logic                  wen;    // Write strobe held for one cycle
    logic [DATA_WIDTH-1:0] addr;   // Byte address
    logic [DATA_WIDTH-1:0] wdata;  // Lane replicated store data
    logic [MASK_WIDTH-1:0] wmask;  // Byte write enables
    logic [DATA_WIDTH-1:0] rdata;  // Raw word that reads zero while en is low

    // Memory stage side
    modport master (
        output en,
        output wen,
        output addr,
        output wdata,
        output wmask,
        input  rdata
    );

    // RAM side
    modport slave (
        input  en,
        input  wen,
        input  addr,
        input  wdata,
        input  wmask,
        output rdata
    );

endinterface : dmem_if

`default_nettype wire

// File: hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Datapath widths
    localparam int DATA_WIDTH     = 32;  // Data, address and instruction
    localparam int REG_ADDR_WIDTH = 5;
    localparam int MASK_WIDTH     = DATA_WIDTH / 8;  // One enable per byte lane

    // Word organized data RAM geometry
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;  // Word index from address bits 9:2

    // Major opcodes handled by this stage
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    // Access size codes
    // Same encoding as funct3 of the load and store formats
    localparam logic [2:0] SIZE_BYTE   = 3'b000;  // LB, SB
    localparam logic [2:0] SIZE_HALF   = 3'b001;  // LH, SH
    localparam logic [2:0] SIZE_WORD   = 3'b010;  // LW, SW
    localparam logic [2:0] SIZE_BYTE_U = 3'b100;  // LBU
    localparam logic [2:0] SIZE_HALF_U = 3'b101;  // LHU

endpackage : mem_pkg

`default_nettype wire
